/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // ============================================================
    // Widths
    // ============================================================
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    // ============================================================
    // Major opcodes kept by this core
    // ============================================================
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // Register and immediate ALU ops
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Conditional branches
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    localparam logic [6:0] FUNCT7_SUB = 7'b0100000; // Alternate encoding, SUB only

endpackage

`default_nettype wire

/* rtl/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    // Sequencer phases, one instruction at a time
    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        DECODE  = 2'd1,
        EXECUTE = 2'd2
    } seq_state_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6   // LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_EQ   = 2'd1,
        BR_NE   = 2'd2,
        BR_JAL  = 2'd3
    } branch_e;

endpackage

`default_nettype wire

/* rtl/rv_decode_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rv_decode_if;

    logic [rv_isa_pkg::REG_IDX_W-1:0] rs1;
    logic [rv_isa_pkg::REG_IDX_W-1:0] rs2;
    logic [rv_isa_pkg::REG_IDX_W-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]      imm;    // Sign-extended, format already applied
    logic [rv_isa_pkg::XLEN-1:0]      pc;
    rv_core_pkg::alu_op_e             alu_op;
    logic                             use_imm;
    logic                             reg_write;
    rv_core_pkg::branch_e             branch;
    logic                             illegal;

    modport dec_mp
    (
        output rs1, rs2, rd, imm, pc, alu_op, use_imm, reg_write, branch, illegal
    );

    modport regs_mp
    (
        input rs1, rs2, rd, reg_write
    );

    modport exec_mp
    (
        input imm, pc, alu_op, use_imm, branch, illegal
    );

endinterface

`default_nettype wire

/* rtl/rv_seq_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_seq_fsm
(
    input   wire        i_clk,
    input   wire        i_arst_n,
    input   wire        i_instr_ack,
    output  logic       o_instr_req,
    output  logic       o_capture,
    output  logic       o_execute
);

    rv_core_pkg::seq_state_e state, state_next;
    logic                    fetch_done;

    assign fetch_done = (state == rv_core_pkg::FETCH) && o_instr_req && i_instr_ack;

    always_comb
    begin
        state_next = state;
        case (state)
            rv_core_pkg::FETCH:
            begin
                if (fetch_done)
                    state_next = rv_core_pkg::DECODE;
            end
            rv_core_pkg::DECODE:  state_next = rv_core_pkg::EXECUTE;
            rv_core_pkg::EXECUTE: state_next = rv_core_pkg::FETCH;
            default:              state_next = rv_core_pkg::FETCH;
        endcase
    end

    // Request is registered so it stays low through reset
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state       <= rv_core_pkg::FETCH;
            o_instr_req <= 1'b0;
        end
        else
        begin
            state       <= state_next;
            o_instr_req <= (state_next == rv_core_pkg::FETCH);
        end
    end

    assign o_capture = fetch_done;                      // Ack cycle
    assign o_execute = (state == rv_core_pkg::EXECUTE);

endmodule

`default_nettype wire

/* rtl/rv_pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_pc_unit
#(
    parameter   logic [rv_isa_pkg::XLEN-1:0] RESET_ADDR = 32'h0000_0000
)
(
    input   wire                            i_clk,
    input   wire                            i_arst_n,
    input   wire                            i_execute,
    input   wire                            i_taken,
    input   wire[rv_isa_pkg::XLEN-1:0]      i_target,
    output  logic[rv_isa_pkg::XLEN-1:0]     o_pc
);

    logic [rv_isa_pkg::XLEN-1:0] pc_next;

    assign pc_next = i_taken ? i_target : (o_pc + 32'd4);

    // Holds through fetch and decode, moves once per instruction
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_pc <= RESET_ADDR;
        else if (i_execute)
            o_pc <= pc_next;
    end

endmodule

`default_nettype wire

/* rtl/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode
(
    input   wire                            i_clk,
    input   wire                            i_arst_n,
    input   wire                            i_capture,
    input   wire[rv_isa_pkg::XLEN-1:0]      i_instr,
    input   wire[rv_isa_pkg::XLEN-1:0]      i_pc,
    rv_decode_if.dec_mp                     dec
);

    localparam logic [rv_isa_pkg::XLEN-1:0] NOP_WORD = 32'h0000_0013; // addi x0, x0, 0

    logic [rv_isa_pkg::XLEN-1:0] instr_q;
    logic [rv_isa_pkg::XLEN-1:0] pc_q;
    logic [6:0]                  opcode;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    logic [rv_isa_pkg::XLEN-1:0] imm_i, imm_u, imm_b, imm_j;
    logic                        bad;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            instr_q <= NOP_WORD;
            pc_q    <= '0;
        end
        else if (i_capture)
        begin
            instr_q <= i_instr;
            pc_q    <= i_pc;
        end
    end

    // ============================================================
    // Field split and immediates
    // ============================================================
    assign opcode = instr_q[6:0];
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];

    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_u = {instr_q[31:12], 12'b0};
    assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                    instr_q[11:8], 1'b0};
    assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                    instr_q[30:21], 1'b0};

    assign dec.rs1 = instr_q[19:15];
    assign dec.rs2 = instr_q[24:20];
    assign dec.rd  = instr_q[11:7];
    assign dec.pc  = pc_q;

    // ============================================================
    // Control decode
    // ============================================================
    always_comb
    begin
        dec.imm       = imm_i;
        dec.alu_op    = rv_core_pkg::ALU_ADD;
        dec.use_imm   = 1'b0;
        dec.reg_write = 1'b0;
        dec.branch    = rv_core_pkg::BR_NONE;
        bad           = 1'b0;

        case (opcode)
            rv_isa_pkg::OP:
            begin
                dec.reg_write = 1'b1;
                if (funct7 == 7'b0)
                begin
                    case (funct3)
                        rv_isa_pkg::F3_ADD_SUB: dec.alu_op = rv_core_pkg::ALU_ADD;
                        rv_isa_pkg::F3_SLT:     dec.alu_op = rv_core_pkg::ALU_SLT;
                        rv_isa_pkg::F3_XOR:     dec.alu_op = rv_core_pkg::ALU_XOR;
                        rv_isa_pkg::F3_OR:      dec.alu_op = rv_core_pkg::ALU_OR;
                        rv_isa_pkg::F3_AND:     dec.alu_op = rv_core_pkg::ALU_AND;
                        default:                bad = 1'b1; // Shifts, SLTU
                    endcase
                end
                else if (funct7 == rv_isa_pkg::FUNCT7_SUB && funct3 == rv_isa_pkg::F3_ADD_SUB)
                    dec.alu_op = rv_core_pkg::ALU_SUB;
                else
                    bad = 1'b1;
            end
            rv_isa_pkg::OP_IMM:
            begin
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: dec.alu_op = rv_core_pkg::ALU_ADD;
                    rv_isa_pkg::F3_SLT:     dec.alu_op = rv_core_pkg::ALU_SLT;
                    rv_isa_pkg::F3_XOR:     dec.alu_op = rv_core_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:      dec.alu_op = rv_core_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND:     dec.alu_op = rv_core_pkg::ALU_AND;
                    default:                bad = 1'b1;
                endcase
            end
            rv_isa_pkg::LUI:
            begin
                dec.imm       = imm_u;
                dec.alu_op    = rv_core_pkg::ALU_PASS_B;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            rv_isa_pkg::BRANCH:
            begin
                dec.imm = imm_b;
                if (funct3 == rv_isa_pkg::F3_BEQ)
                    dec.branch = rv_core_pkg::BR_EQ;
                else if (funct3 == rv_isa_pkg::F3_BNE)
                    dec.branch = rv_core_pkg::BR_NE;
                else
                    bad = 1'b1;
            end
            rv_isa_pkg::JAL:
            begin
                dec.imm       = imm_j;
                dec.reg_write = 1'b1; // Link value comes from the ALU
                dec.branch    = rv_core_pkg::BR_JAL;
            end
            default: bad = 1'b1;
        endcase

        // Unsupported word retires as a no-op
        if (bad)
        begin
            dec.reg_write = 1'b0;
            dec.branch    = rv_core_pkg::BR_NONE;
        end
        dec.illegal = bad;
    end

endmodule

`default_nettype wire

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
(
    input   wire                                i_clk,
    input   wire                                i_arst_n,
    input   wire                                i_execute,
    input   wire[rv_isa_pkg::XLEN-1:0]          i_wdata,
    rv_decode_if.regs_mp                        regs,
    output  logic[rv_isa_pkg::XLEN-1:0]         o_rdata1,
    output  logic[rv_isa_pkg::XLEN-1:0]         o_rdata2,
    output  logic                               o_wb_valid,
    output  logic[rv_isa_pkg::REG_IDX_W-1:0]    o_wb_rd,
    output  logic[rv_isa_pkg::XLEN-1:0]         o_wb_data
);

    logic [rv_isa_pkg::XLEN-1:0] gpr [1:31];   // x0 has no storage
    logic                        wr_en;

    assign wr_en = i_execute && regs.reg_write && (regs.rd != '0);

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int i = 1; i < 32; i++)
                gpr[i] <= '0;
        end
        else if (wr_en)
            gpr[regs.rd] <= i_wdata;
    end

    assign o_rdata1 = (regs.rs1 == '0) ? '0 : gpr[regs.rs1];
    assign o_rdata2 = (regs.rs2 == '0) ? '0 : gpr[regs.rs2];

    // Trace of every register write
    assign o_wb_valid = wr_en;
    assign o_wb_rd    = regs.rd;
    assign o_wb_data  = i_wdata;

endmodule

`default_nettype wire

/* rtl/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu
(
    input   wire[rv_isa_pkg::XLEN-1:0]      i_rdata1,
    input   wire[rv_isa_pkg::XLEN-1:0]      i_rdata2,
    rv_decode_if.exec_mp                    exec,
    output  logic[rv_isa_pkg::XLEN-1:0]     o_result,
    output  logic                           o_taken,
    output  logic[rv_isa_pkg::XLEN-1:0]     o_target
);

    logic [rv_isa_pkg::XLEN-1:0] op_b;
    logic [rv_isa_pkg::XLEN-1:0] link;
    logic [rv_isa_pkg::XLEN-1:0] arith;
    logic                        cond;

    assign op_b = exec.use_imm ? exec.imm : i_rdata2;
    assign link = exec.pc + 32'd4;

    always_comb
    begin
        case (exec.alu_op)
            rv_core_pkg::ALU_ADD:    arith = i_rdata1 + op_b;
            rv_core_pkg::ALU_SUB:    arith = i_rdata1 - op_b;
            rv_core_pkg::ALU_AND:    arith = i_rdata1 & op_b;
            rv_core_pkg::ALU_OR:     arith = i_rdata1 | op_b;
            rv_core_pkg::ALU_XOR:    arith = i_rdata1 ^ op_b;
            rv_core_pkg::ALU_SLT:    arith = {31'b0, $signed(i_rdata1) < $signed(op_b)};
            rv_core_pkg::ALU_PASS_B: arith = op_b;
            default:                 arith = '0;
        endcase
    end

    // ============================================================
    // Control flow
    // ============================================================
    always_comb
    begin
        case (exec.branch)
            rv_core_pkg::BR_EQ:  cond = (i_rdata1 == i_rdata2);
            rv_core_pkg::BR_NE:  cond = (i_rdata1 != i_rdata2);
            rv_core_pkg::BR_JAL: cond = 1'b1;
            default:             cond = 1'b0;
        endcase
    end

    assign o_result = (exec.branch == rv_core_pkg::BR_JAL) ? link : arith;
    assign o_taken  = cond && !exec.illegal;    // Illegal words never redirect
    assign o_target = exec.pc + exec.imm;

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core
#(
    parameter   logic [rv_isa_pkg::XLEN-1:0] RESET_ADDR = 32'h0000_0000
)
(
    input   wire                                i_clk,
    input   wire                                i_arst_n,
    // Instruction bus
    output  logic                               o_instr_req,
    output  logic[rv_isa_pkg::XLEN-1:0]         o_instr_addr,
    input   wire                                i_instr_ack,
    input   wire[rv_isa_pkg::XLEN-1:0]          i_instr_data,
    // Write-back trace
    output  logic                               o_wb_valid,
    output  logic[rv_isa_pkg::REG_IDX_W-1:0]    o_wb_rd,
    output  logic[rv_isa_pkg::XLEN-1:0]         o_wb_data,
    output  logic                               o_illegal
);

    logic                        capture;
    logic                        execute;
    logic [rv_isa_pkg::XLEN-1:0] pc;
    logic [rv_isa_pkg::XLEN-1:0] rdata1, rdata2;
    logic [rv_isa_pkg::XLEN-1:0] alu_result;
    logic                        taken;
    logic [rv_isa_pkg::XLEN-1:0] target;

    rv_decode_if dec_bus ();

    rv_seq_fsm
    u_seq
    (
        .i_clk                          (i_clk),
        .i_arst_n                       (i_arst_n),
        .i_instr_ack                    (i_instr_ack),
        .o_instr_req                    (o_instr_req),
        .o_capture                      (capture),
        .o_execute                      (execute)
    );

    rv_pc_unit
    #(
        .RESET_ADDR                     (RESET_ADDR)
    )
    u_pc
    (
        .i_clk                          (i_clk),
        .i_arst_n                       (i_arst_n),
        .i_execute                      (execute),
        .i_taken                        (taken),
        .i_target                       (target),
        .o_pc                           (pc)
    );

    assign o_instr_addr = pc;

    rv_decode
    u_decode
    (
        .i_clk                          (i_clk),
        .i_arst_n                       (i_arst_n),
        .i_capture                      (capture),
        .i_instr                        (i_instr_data),
        .i_pc                           (pc),
        .dec                            (dec_bus.dec_mp)
    );

    rv_regfile
    u_regs
    (
        .i_clk                          (i_clk),
        .i_arst_n                       (i_arst_n),
        .i_execute                      (execute),
        .i_wdata                        (alu_result),
        .regs                           (dec_bus.regs_mp),
        .o_rdata1                       (rdata1),
        .o_rdata2                       (rdata2),
        .o_wb_valid                     (o_wb_valid),
        .o_wb_rd                        (o_wb_rd),
        .o_wb_data                      (o_wb_data)
    );

    rv_alu
    u_alu
    (
        .i_rdata1                       (rdata1),
        .i_rdata2                       (rdata2),
        .exec                           (dec_bus.exec_mp),
        .o_result                       (alu_result),
        .o_taken                        (taken),
        .o_target                       (target)
    );

    assign o_illegal = dec_bus.illegal & execute;   // One pulse per bad word

endmodule

`default_nettype wire

/* sim/rv_core_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_sva
(
    input   wire        i_clk,
    input   wire        i_arst_n,
    input   wire        o_instr_req,
    input   wire[31:0]  o_instr_addr,
    input   wire        i_instr_ack,
    input   wire        o_wb_valid,
    input   wire[4:0]   o_wb_rd,
    input   wire        o_illegal
);

    // ============================================================
    // Instruction bus
    // ============================================================
    req_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_instr_req && !i_instr_ack |=> o_instr_req && $stable(o_instr_addr))
        else $error("request dropped or address moved before ack");

    req_in_reset: assert property (@(posedge i_clk) !i_arst_n |-> !o_instr_req)
        else $error("request raised during reset");

    // Write-back trace
    wb_or_illegal: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(o_wb_valid && o_illegal))
        else $error("write-back and illegal pulse together");

    wb_rd_nonzero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_wb_valid |-> o_wb_rd != 5'd0)
        else $error("write-back to x0");

endmodule

bind rv_core rv_core_sva u_sva
(
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .o_instr_req    (o_instr_req),
    .o_instr_addr   (o_instr_addr),
    .i_instr_ack    (i_instr_ack),
    .o_wb_valid     (o_wb_valid),
    .o_wb_rd        (o_wb_rd),
    .o_illegal      (o_illegal)
);

`default_nettype wire

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam logic [31:0] RESET_ADDR   = 32'h0000_1000;
    localparam int          SEED         = 21;
    localparam int          N_INSTR      = 400;
    localparam int          MAX_DELAY    = 4;
    localparam int          RESET_CYCLES = 8;
    localparam int          CYCLES_PER   = MAX_DELAY + 4; // Wait, ack, decode, execute
    localparam int          MARGIN       = 100;

    logic        i_clk = 1'b0;
    logic        i_arst_n;
    logic        i_instr_ack;
    logic [31:0] i_instr_data;
    logic        o_instr_req;
    logic [31:0] o_instr_addr;
    logic        o_wb_valid;
    logic [4:0]  o_wb_rd;
    logic [31:0] o_wb_data;
    logic        o_illegal;

    logic [31:0] mem [logic [31:0]];  // Sparse program memory
    logic [31:0] regs [0:31];
    logic [31:0] model_pc = RESET_ADDR;
    int          test_checks [1:6];
    int          test_errors [1:6];
    int          countdown, wait_cnt, issued, retired, model_wb_count, wb_seen, req_rises;
    int          result_test, addr_test = 1;
    logic        waiting, req_prev;
    logic        exp_wb, exp_illegal;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;

    rv_core #(.RESET_ADDR(RESET_ADDR)) rv_core_inst
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .o_instr_req    (o_instr_req),
        .o_instr_addr   (o_instr_addr),
        .i_instr_ack    (i_instr_ack),
        .i_instr_data   (i_instr_data),
        .o_wb_valid     (o_wb_valid),
        .o_wb_rd        (o_wb_rd),
        .o_wb_data      (o_wb_data),
        .o_illegal      (o_illegal)
    );

    always #50 i_clk = ~i_clk;

    task automatic check(input int test_id, input logic [31:0] got, input logic [31:0] exp,
                         input string what);
        test_checks[test_id]++;
        if (got !== exp)
        begin
            test_errors[test_id]++;
            $display("error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic string test_label(input int id);
        case (id)
            1:       return "reset";
            2:       return "arithmetic";
            3:       return "control flow";
            4:       return "x0 rule";
            5:       return "illegal words";
            default: return "ack latency and counts";
        endcase
    endfunction

    // ============================================================
    // Random program words, branches only jump forward
    // ============================================================
    function automatic logic [31:0] gen_instr();
        int unsigned pick;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        pick = $urandom_range(0, 99);
        rd   = 5'($urandom_range(0, 7));
        rs1  = 5'($urandom_range(0, 7));
        rs2  = 5'($urandom_range(0, 7));
        imm  = 12'($urandom);
        boff = 13'(4 * $urandom_range(1, 4));
        joff = 21'(4 * $urandom_range(1, 4));
        f3   = 3'($urandom_range(0, 4));
        if (f3 == 3'd1)
            f3 = 3'd7;
        if (f3 == 3'd3)
            f3 = 3'd6;
        if (pick < 30)
            return {(f3 == 3'd0 && pick < 10) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
        else if (pick < 55)
            return {imm, rs1, f3, rd, 7'h13};
        else if (pick < 65)
            return {20'($urandom), rd, 7'h37};
        else if (pick < 80)
            return {boff[12], boff[10:5], rs2, rs1, 3'(pick % 2), boff[4:1], boff[11], 7'h63};
        else if (pick < 90)
            return {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'h6f};
        else if (pick < 94)
            return {imm, rs1, 3'b001, rd, 7'h13};   // SLLI
        else if (pick < 97)
            return {imm, rs1, 3'b010, rd, 7'h03};   // Load
        return 32'h0010_0073;                       // ebreak
    endfunction

    // Reference model, one instruction per ack
    task automatic model_step(input logic [31:0] w);
        logic [6:0]  op;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a, b, opb, imm_i, imm_b, imm_j, val;
        logic        legal, wr, taken;
        op    = w[6:0];
        f7    = w[31:25];
        f3    = w[14:12];
        rd    = w[11:7];
        a     = regs[w[19:15]];
        b     = regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        val   = '0;
        legal = 1'b1;
        wr    = 1'b0;
        taken = 1'b0;
        case (op)
            7'h33, 7'h13:
            begin
                wr  = 1'b1;
                opb = (op == 7'h33) ? b : imm_i;
                case (f3)
                    3'd0:    val = (op == 7'h33 && f7 == 7'h20) ? a - opb : a + opb;
                    3'd2:    val = {31'b0, $signed(a) < $signed(opb)};
                    3'd4:    val = a ^ opb;
                    3'd6:    val = a | opb;
                    3'd7:    val = a & opb;
                    default: legal = 1'b0;
                endcase
                if (op == 7'h33 && f7 != 7'h00 && !(f7 == 7'h20 && f3 == 3'd0))
                    legal = 1'b0;
            end
            7'h37:
            begin
                wr  = 1'b1;
                val = {w[31:12], 12'b0};
            end
            7'h63:
            begin
                if (f3 == 3'd0)
                    taken = (a == b);
                else if (f3 == 3'd1)
                    taken = (a != b);
                else
                    legal = 1'b0;
            end
            7'h6f:
            begin
                wr    = 1'b1;
                val   = model_pc + 32'd4;   // Link
                taken = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        if (!legal)
        begin
            wr    = 1'b0;
            taken = 1'b0;
        end

        exp_wb      = wr && rd != 5'd0;
        exp_rd      = rd;
        exp_data    = val;
        exp_illegal = !legal;
        if (!legal)
            result_test = 5;
        else if (op == 7'h63 || op == 7'h6f)
            result_test = 3;
        else if (wr && rd == 5'd0)
            result_test = 4;
        else
            result_test = 2;
        addr_test = result_test == 5 ? 5 : (result_test == 3 ? 3 : 6);
        if (exp_wb)
        begin
            regs[rd] = val;
            model_wb_count++;
        end
        model_pc = taken ? model_pc + ((op == 7'h6f) ? imm_j : imm_b) : model_pc + 32'd4;
        retired++;
    endtask

    // ============================================================
    // Memory responder, monitor and checks
    // ============================================================
    always @(posedge i_clk)
    begin
        if (!i_arst_n)
            i_instr_ack <= 1'b0;
        else
        begin
            if (countdown == 1)     // Execute cycle of the last fetched word
            begin
                check(result_test, {31'b0, o_illegal}, {31'b0, exp_illegal}, "illegal pulse");
                check(result_test, {31'b0, o_wb_valid}, {31'b0, exp_wb}, "write-back valid");
                if (exp_wb)
                begin
                    check(result_test, {27'b0, o_wb_rd}, {27'b0, exp_rd}, "write-back rd");
                    check(result_test, o_wb_data, exp_data, "write-back data");
                end
            end
            else
                check(retired == 0 ? 1 : 6, {30'b0, o_wb_valid, o_illegal}, 32'd0,
                      "pulse outside execute");
            if (countdown != 0)
                countdown--;
            if (o_wb_valid)
                wb_seen++;
            if (o_instr_req && !req_prev)
                req_rises++;
            req_prev = o_instr_req;

            if (i_instr_ack)
            begin
                i_instr_ack <= 1'b0;
                check(addr_test, o_instr_addr, model_pc, "fetch address");
                model_step(i_instr_data);
                countdown = 2;
            end
            else if (o_instr_req && issued < N_INSTR)
            begin
                if (!waiting)
                begin
                    wait_cnt = $urandom_range(0, MAX_DELAY);
                    waiting  = 1'b1;
                end
                if (wait_cnt == 0)
                begin
                    if (!mem.exists(o_instr_addr))
                        mem[o_instr_addr] = gen_instr();
                    i_instr_data <= mem[o_instr_addr];
                    i_instr_ack  <= 1'b1;
                    waiting = 1'b0;
                    issued++;
                end
                else
                    wait_cnt--;
            end
        end
    end

    initial
    begin
        repeat (RESET_CYCLES + N_INSTR * CYCLES_PER + MARGIN) @(posedge i_clk);
        $display("Timeout: the core stopped fetching or retiring instructions");
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        int total_checks;
        int total_errors;
        void'($urandom(SEED));
        i_arst_n     = 1'b0;
        i_instr_ack  = 1'b0;
        i_instr_data = '0;
        waiting      = 1'b0;
        req_prev     = 1'b0;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_arst_n <= 1'b1;

        wait (retired == N_INSTR && countdown == 0);
        repeat (3) @(posedge i_clk);
        check(6, wb_seen, model_wb_count, "write-back count");
        check(6, req_rises, retired + 1, "fetch count");   // Last request stays open

        total_checks = 0;
        total_errors = 0;
        for (int t = 1; t <= 6; t++)
        begin
            $display("test %0d %s: %0d checks, %0d errors", t, test_label(t),
                     test_checks[t], test_errors[t]);
            total_checks += test_checks[t];
            total_errors += test_errors[t];
        end
        $display("%0d instructions, %0d checks, %0d errors", retired, total_checks, total_errors);
        if (total_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
rtl/rv_isa_pkg.sv
rtl/rv_core_pkg.sv
rtl/rv_decode_if.sv
rtl/rv_seq_fsm.sv
rtl/rv_pc_unit.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_core.sv
sim/rv_core_sva.sv
sim/tb_rv_core.sv

/* Makefile */
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_rv_core
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q -x '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
